// File: layers_pkg.sv
`default_nettype none

package layers_pkg;

    // configuration bus widths
    localparam int CFG_DWIDTH = 32;
    localparam int CFG_AWIDTH = 5;

    // address of the layer stage configuration word
    localparam logic [CFG_AWIDTH-1:0] CFG_LAYERS = 5'd2;

    // field widths inside the configuration word
    localparam int POOL_W = 8;
    localparam int SHIFT_W = 8;

    // bit 16 bypass, bits 15:8 pool_nb, bits 7:0 shift
    typedef struct packed {
        logic               bypass;
        logic [POOL_W-1:0]  pool_nb;
        logic [SHIFT_W-1:0] shift;
    } layers_cfg_t;

    // intake side
    typedef enum logic [1:0] {
        UP_IDLE,
        UP_READY,
        UP_DONE,
        UP_HANDOFF
    } up_state_t;

    // pooling side, one stage per state
    typedef enum logic [2:0] {
        DN_IDLE,
        DN_WAIT,
        DN_ADD,
        DN_POOL,
        DN_OPS,
        DN_OUT
    } dn_state_t;

endpackage

`default_nettype wire

// File: layers_cfg_decode.sv
`default_nettype none

module layers_cfg_decode (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [layers_pkg::CFG_DWIDTH-1:0] cfg_data,
    input  logic [layers_pkg::CFG_AWIDTH-1:0] cfg_addr,
    input  logic                              cfg_valid,
    output layers_pkg::layers_cfg_t           cfg
);

    import layers_pkg::*;

    logic hit;

    // only words aimed at this stage are taken
    assign hit = cfg_valid && (cfg_addr == CFG_LAYERS);

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg <= '0;
        end else if (hit) begin
            cfg.bypass  <= cfg_data[SHIFT_W+POOL_W];
            cfg.pool_nb <= cfg_data[SHIFT_W +: POOL_W];
            cfg.shift   <= cfg_data[SHIFT_W-1:0];
        end
    end

endmodule

`default_nettype wire

// File: layers_mac_front.sv
`default_nettype none

module layers_mac_front #(
    parameter int  DEPTH_NB  = 4,
    parameter int  GROUP_NB  = 2,
    parameter int  IMG_WIDTH = 8,
    parameter int  KER_WIDTH = 8,
    localparam int NUM_WIDTH = IMG_WIDTH + KER_WIDTH + 4
) (
    input  logic                                             clk,
    input  logic                                             rst,
    input  logic [GROUP_NB-1:0][IMG_WIDTH-1:0]               image_bus,
    input  logic                                             image_last,
    input  logic                                             image_val,
    output logic                                             image_rdy,
    output logic                                             kernel_rdy,
    input  logic [DEPTH_NB-1:0][GROUP_NB-1:0][KER_WIDTH-1:0] kernel_bus,
    output logic [DEPTH_NB-1:0][GROUP_NB-1:0][NUM_WIDTH-1:0] hold_bus,
    output logic                                             hold_val,
    input  logic                                             hold_take
);

    import layers_pkg::*;

    up_state_t                                        state;
    up_state_t                                        state_nx;
    logic                                             accept;
    logic                                             last_q;
    logic                                             fresh;
    logic [GROUP_NB-1:0][IMG_WIDTH-1:0]               image_q;
    logic [DEPTH_NB-1:0][GROUP_NB-1:0][NUM_WIDTH-1:0] prod;
    logic [DEPTH_NB-1:0][GROUP_NB-1:0][NUM_WIDTH-1:0] acc;

    assign image_rdy = (state == UP_READY);
    assign hold_val  = (state == UP_HANDOFF);
    assign accept    = image_val & image_rdy;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= UP_IDLE;
        end else begin
            state <= state_nx;
        end
    end

    always_comb begin
        state_nx = state;
        case (state)
            UP_IDLE:    state_nx = UP_READY;
            UP_READY:   if (accept && image_last) state_nx = UP_DONE;
            // the last product lands in acc while kernel_rdy is high
            UP_DONE:    if (!kernel_rdy) state_nx = UP_HANDOFF;
            UP_HANDOFF: if (hold_take) state_nx = UP_READY;
            default:    state_nx = UP_IDLE;
        endcase
    end

    // kernel is requested the cycle after each beat
    always_ff @(posedge clk) begin
        if (rst) begin
            kernel_rdy <= 1'b0;
            fresh      <= 1'b1;
        end else begin
            kernel_rdy <= accept;
            if (kernel_rdy) begin
                fresh <= last_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            image_q <= image_bus;
            last_q  <= image_last;
        end
    end

    always_comb begin
        for (int d = 0; d < DEPTH_NB; d++) begin
            for (int g = 0; g < GROUP_NB; g++) begin
                prod[d][g] = NUM_WIDTH'($signed(image_q[g]) * $signed(kernel_bus[d][g]));
            end
        end
    end

    // first beat of a frame restarts the sums
    always_ff @(posedge clk) begin
        if (kernel_rdy) begin
            for (int d = 0; d < DEPTH_NB; d++) begin
                for (int g = 0; g < GROUP_NB; g++) begin
                    acc[d][g] <= fresh ? prod[d][g] : acc[d][g] + prod[d][g];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if ((state == UP_DONE) && (state_nx == UP_HANDOFF)) begin
            hold_bus <= acc;
        end
    end

endmodule

`default_nettype wire

// File: layers_pool_chain.sv
`default_nettype none

module layers_pool_chain #(
    parameter int  DEPTH_NB  = 4,
    parameter int  GROUP_NB  = 2,
    parameter int  IMG_WIDTH = 8,
    parameter int  KER_WIDTH = 8,
    localparam int NUM_WIDTH = IMG_WIDTH + KER_WIDTH + 4
) (
    input  logic                                             clk,
    input  logic                                             rst,
    input  layers_pkg::layers_cfg_t                          cfg,
    input  logic [DEPTH_NB-1:0][GROUP_NB-1:0][NUM_WIDTH-1:0] hold_bus,
    input  logic                                             hold_val,
    output logic                                             hold_take,
    input  logic [DEPTH_NB-1:0][KER_WIDTH-1:0]               bias_bus,
    output logic [DEPTH_NB-1:0][NUM_WIDTH-1:0]               act_bus,
    output logic                                             act_val,
    input  logic                                             out_done
);

    import layers_pkg::*;

    dn_state_t                          state;
    dn_state_t                          state_nx;
    logic [POOL_W-1:0]                  pool_cnt;
    logic                               pool_last;
    logic [DEPTH_NB-1:0][NUM_WIDTH-1:0] lane_sum;
    logic [DEPTH_NB-1:0][NUM_WIDTH-1:0] sum_q;
    logic [DEPTH_NB-1:0][NUM_WIDTH-1:0] pool_max;
    logic [DEPTH_NB-1:0][NUM_WIDTH-1:0] bias_q;

    assign hold_take = (state == DN_WAIT) && hold_val;
    assign act_val   = (state == DN_OPS);
    assign pool_last = (pool_cnt == cfg.pool_nb);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= DN_IDLE;
        end else begin
            state <= state_nx;
        end
    end

    always_comb begin
        state_nx = state;
        case (state)
            DN_IDLE: state_nx = DN_WAIT;
            DN_WAIT: if (hold_take) state_nx = DN_ADD;
            DN_ADD:  state_nx = DN_POOL;
            DN_POOL: state_nx = pool_last ? DN_OPS : DN_WAIT;
            DN_OPS:  state_nx = DN_OUT;
            // stay until the result has left the port
            DN_OUT:  if (out_done) state_nx = DN_WAIT;
            default: state_nx = DN_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pool_cnt <= '0;
        end else if (state == DN_POOL) begin
            pool_cnt <= pool_last ? '0 : pool_cnt + 1'b1;
        end
    end

    always_comb begin
        for (int d = 0; d < DEPTH_NB; d++) begin
            lane_sum[d] = '0;
            for (int g = 0; g < GROUP_NB; g++) begin
                lane_sum[d] = lane_sum[d] + hold_bus[d][g];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hold_take) begin
            sum_q <= lane_sum;
        end
        for (int d = 0; d < DEPTH_NB; d++) begin
            // first frame of a window loads the maximum outright
            if ((state == DN_ADD) &&
                ((pool_cnt == '0) || ($signed(sum_q[d]) > $signed(pool_max[d])))) begin
                pool_max[d] <= sum_q[d];
            end
            if (state == DN_POOL) begin
                bias_q[d] <= pool_max[d] + NUM_WIDTH'($signed(bias_bus[d]));
            end
        end
    end

    // relu, skipped when bypass is set
    always_comb begin
        for (int d = 0; d < DEPTH_NB; d++) begin
            act_bus[d] = (!cfg.bypass && bias_q[d][NUM_WIDTH-1]) ? '0 : bias_q[d];
        end
    end

endmodule

`default_nettype wire

// File: layers_result.sv
`default_nettype none

module layers_result #(
    parameter int  DEPTH_NB  = 4,
    parameter int  IMG_WIDTH = 8,
    parameter int  KER_WIDTH = 8,
    localparam int NUM_WIDTH = IMG_WIDTH + KER_WIDTH + 4
) (
    input  logic                                clk,
    input  logic                                rst,
    input  layers_pkg::layers_cfg_t             cfg,
    input  logic [DEPTH_NB-1:0][NUM_WIDTH-1:0]  act_bus,
    input  logic                                act_val,
    output logic                                out_done,
    output logic [DEPTH_NB-1:0][IMG_WIDTH-1:0]  result_bus,
    output logic                                result_val,
    input  logic                                result_rdy
);

    // signed limits of the output pixel
    localparam logic signed [NUM_WIDTH-1:0] SAT_MAX = NUM_WIDTH'((1 << (IMG_WIDTH - 1)) - 1);
    localparam logic signed [NUM_WIDTH-1:0] SAT_MIN = -SAT_MAX - 1;

    logic                               shift_val;
    logic [DEPTH_NB-1:0][NUM_WIDTH-1:0] shift_q;

    function automatic logic [IMG_WIDTH-1:0] saturate(input logic signed [NUM_WIDTH-1:0] value);
        logic signed [NUM_WIDTH-1:0] clip;
        if (value > SAT_MAX) begin
            clip = SAT_MAX;
        end else if (value < SAT_MIN) begin
            clip = SAT_MIN;
        end else begin
            clip = value;
        end
        return clip[IMG_WIDTH-1:0];
    endfunction

    assign out_done = result_val & result_rdy;

    always_ff @(posedge clk) begin
        if (rst) begin
            shift_val  <= 1'b0;
            result_val <= 1'b0;
        end else begin
            shift_val <= act_val;
            if (shift_val) begin
                result_val <= 1'b1;
            end else if (result_rdy) begin
                result_val <= 1'b0;
            end
        end
    end

    // arithmetic shift, then clip into the pixel range
    always_ff @(posedge clk) begin
        for (int d = 0; d < DEPTH_NB; d++) begin
            if (act_val) begin
                shift_q[d] <= $signed(act_bus[d]) >>> cfg.shift;
            end
            if (shift_val) begin
                result_bus[d] <= saturate(shift_q[d]);
            end
        end
    end

endmodule

`default_nettype wire

// File: layers.sv
`default_nettype none

module layers #(
    parameter int DEPTH_NB  = 4,
    parameter int GROUP_NB  = 2,
    parameter int IMG_WIDTH = 8,
    parameter int KER_WIDTH = 8
) (
    input  logic                                             clk,
    input  logic                                             rst,
    input  logic [layers_pkg::CFG_DWIDTH-1:0]                cfg_data,
    input  logic [layers_pkg::CFG_AWIDTH-1:0]                cfg_addr,
    input  logic                                             cfg_valid,
    input  logic [GROUP_NB-1:0][IMG_WIDTH-1:0]               image_bus,
    input  logic                                             image_last,
    input  logic                                             image_val,
    output logic                                             image_rdy,
    input  logic [DEPTH_NB-1:0][GROUP_NB-1:0][KER_WIDTH-1:0] kernel_bus,
    output logic                                             kernel_rdy,
    input  logic [DEPTH_NB-1:0][KER_WIDTH-1:0]               bias_bus,
    output logic [DEPTH_NB-1:0][IMG_WIDTH-1:0]               result_bus,
    output logic                                             result_val,
    input  logic                                             result_rdy
);

    import layers_pkg::*;

    localparam int NUM_WIDTH = IMG_WIDTH + KER_WIDTH + 4;

    layers_cfg_t                                      cfg;
    logic [DEPTH_NB-1:0][GROUP_NB-1:0][NUM_WIDTH-1:0] hold_bus;
    logic                                             hold_val;
    logic                                             hold_take;
    logic [DEPTH_NB-1:0][NUM_WIDTH-1:0]               act_bus;
    logic                                             act_val;
    logic                                             out_done;

    layers_cfg_decode u_cfg (
        .clk       (clk),
        .rst       (rst),
        .cfg_data  (cfg_data),
        .cfg_addr  (cfg_addr),
        .cfg_valid (cfg_valid),
        .cfg       (cfg)
    );

    // intake and accumulate, one frame at a time
    layers_mac_front #(
        .DEPTH_NB  (DEPTH_NB),
        .GROUP_NB  (GROUP_NB),
        .IMG_WIDTH (IMG_WIDTH),
        .KER_WIDTH (KER_WIDTH)
    ) u_mac (
        .clk        (clk),
        .rst        (rst),
        .image_bus  (image_bus),
        .image_last (image_last),
        .image_val  (image_val),
        .image_rdy  (image_rdy),
        .kernel_rdy (kernel_rdy),
        .kernel_bus (kernel_bus),
        .hold_bus   (hold_bus),
        .hold_val   (hold_val),
        .hold_take  (hold_take)
    );

    layers_pool_chain #(
        .DEPTH_NB  (DEPTH_NB),
        .GROUP_NB  (GROUP_NB),
        .IMG_WIDTH (IMG_WIDTH),
        .KER_WIDTH (KER_WIDTH)
    ) u_pool (
        .clk       (clk),
        .rst       (rst),
        .cfg       (cfg),
        .hold_bus  (hold_bus),
        .hold_val  (hold_val),
        .hold_take (hold_take),
        .bias_bus  (bias_bus),
        .act_bus   (act_bus),
        .act_val   (act_val),
        .out_done  (out_done)
    );

    layers_result #(
        .DEPTH_NB  (DEPTH_NB),
        .IMG_WIDTH (IMG_WIDTH),
        .KER_WIDTH (KER_WIDTH)
    ) u_result (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg),
        .act_bus    (act_bus),
        .act_val    (act_val),
        .out_done   (out_done),
        .result_bus (result_bus),
        .result_val (result_val),
        .result_rdy (result_rdy)
    );

endmodule

`default_nettype wire

// File: tb_layers.sv
`default_nettype none

module tb_layers;

    import layers_pkg::*;

    localparam int DEPTH_NB  = 4;
    localparam int GROUP_NB  = 2;
    localparam int IMG_WIDTH = 8;
    localparam int KER_WIDTH = 8;
    localparam int WAIT_MAX  = 200;
    // stimulus flavours for pixels and weights
    localparam int MODE_POS = 0;
    localparam int MODE_NEG = 1;
    localparam int MODE_BIG = 2;
    localparam int MODE_MIX = 3;

    logic                                             clk;
    logic                                             rst;
    logic [CFG_DWIDTH-1:0]                            cfg_data;
    logic [CFG_AWIDTH-1:0]                            cfg_addr;
    logic                                             cfg_valid;
    logic [GROUP_NB-1:0][IMG_WIDTH-1:0]               image_bus;
    logic                                             image_last;
    logic                                             image_val;
    logic                                             image_rdy;
    logic [DEPTH_NB-1:0][GROUP_NB-1:0][KER_WIDTH-1:0] kernel_bus;
    logic                                             kernel_rdy;
    logic [DEPTH_NB-1:0][KER_WIDTH-1:0]               bias_bus;
    logic [DEPTH_NB-1:0][IMG_WIDTH-1:0]               result_bus;
    logic                                             result_val;
    logic                                             result_rdy;

    // model of the configuration and of the pooling window
    int          bypass_m;
    int          pool_nb_m;
    int          shift_m;
    int          bias_m[DEPTH_NB];
    int          frame_sum[DEPTH_NB];
    int          pool_m[DEPTH_NB];
    int          pooled;
    logic [31:0] lfsr_q;
    logic [DEPTH_NB-1:0][IMG_WIDTH-1:0] exp_q[$];
    logic [DEPTH_NB-1:0][IMG_WIDTH-1:0] want;

    // state seen at the previous edge
    logic                               armed;
    logic                               rst_q;
    logic                               accept_q;
    logic                               val_q;
    logic                               rdy_q;
    logic [DEPTH_NB-1:0][IMG_WIDTH-1:0] bus_q;

    layers #(
        .DEPTH_NB  (DEPTH_NB),
        .GROUP_NB  (GROUP_NB),
        .IMG_WIDTH (IMG_WIDTH),
        .KER_WIDTH (KER_WIDTH)
    ) dut0 (
        .clk        (clk),
        .rst        (rst),
        .cfg_data   (cfg_data),
        .cfg_addr   (cfg_addr),
        .cfg_valid  (cfg_valid),
        .image_bus  (image_bus),
        .image_last (image_last),
        .image_val  (image_val),
        .image_rdy  (image_rdy),
        .kernel_bus (kernel_bus),
        .kernel_rdy (kernel_rdy),
        .bias_bus   (bias_bus),
        .result_bus (result_bus),
        .result_val (result_val),
        .result_rdy (result_rdy)
    );

    always #20 clk = ~clk;

    task automatic value_error(input string name, input int got, input int exp);
        $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic stop_error(input string what);
        $display("%0t %s", $time, what);
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_q[0]);
            lfsr_q = lfsr_next(lfsr_q);
        end
        return v;
    endfunction

    function automatic int draw_pixel(input int mode);
        case (mode)
            MODE_POS: return rand_bits(3);
            MODE_NEG: return rand_bits(3) | 1;
            MODE_BIG: return rand_bits(1) - 8;
            default:  return rand_bits(4) - 8;
        endcase
    endfunction

    function automatic int draw_weight(input int mode);
        case (mode)
            MODE_POS: return rand_bits(3);
            MODE_NEG: return -1 - rand_bits(3);
            MODE_BIG: return -8;
            default:  return rand_bits(4) - 8;
        endcase
    endfunction

    // relu, arithmetic shift, then clip to the pixel range
    function automatic int scale_value(input int v);
        int r;
        r = v;
        if (bypass_m == 0 && r < 0) begin
            r = 0;
        end
        r = r >>> shift_m;
        if (r > (1 << (IMG_WIDTH - 1)) - 1) begin
            r = (1 << (IMG_WIDTH - 1)) - 1;
        end else if (r < -(1 << (IMG_WIDTH - 1))) begin
            r = -(1 << (IMG_WIDTH - 1));
        end
        return r;
    endfunction

    task automatic write_cfg(input int addr, input int bypass, input int pool_nb, input int shift);
        cfg_addr  <= CFG_AWIDTH'(addr);
        cfg_data  <= CFG_DWIDTH'((bypass << 16) | (pool_nb << 8) | shift);
        cfg_valid <= 1'b1;
        @(posedge clk);
        cfg_valid <= 1'b0;
        if (addr == int'(CFG_LAYERS)) begin
            bypass_m  = bypass;
            pool_nb_m = pool_nb;
            shift_m   = shift;
        end
    endtask

    task automatic set_bias(input int base, input int span);
        for (int d = 0; d < DEPTH_NB; d++) begin
            bias_m[d] = base + rand_bits(span);
            bias_bus[d] <= KER_WIDTH'(bias_m[d]);
        end
    endtask

    task automatic send_frame(input int beats, input int mode);
        int px[GROUP_NB];
        int w;
        int waited;
        for (int d = 0; d < DEPTH_NB; d++) begin
            frame_sum[d] = 0;
        end
        for (int b = 0; b < beats; b++) begin
            for (int g = 0; g < GROUP_NB; g++) begin
                px[g] = draw_pixel(mode);
                image_bus[g] <= IMG_WIDTH'(px[g]);
            end
            image_last <= (b == beats - 1);
            image_val  <= 1'b1;
            waited = 0;
            do begin
                @(posedge clk);
                waited++;
                if (waited > WAIT_MAX) begin
                    stop_error("timeout, image beat was never accepted");
                end
            end while (!image_rdy);
            // weights for this beat, present while kernel_rdy is high
            for (int d = 0; d < DEPTH_NB; d++) begin
                for (int g = 0; g < GROUP_NB; g++) begin
                    w = draw_weight(mode);
                    kernel_bus[d][g] <= KER_WIDTH'(w);
                    frame_sum[d] += px[g] * w;
                end
            end
        end
        image_val  <= 1'b0;
        image_last <= 1'b0;
        for (int d = 0; d < DEPTH_NB; d++) begin
            if (pooled == 0 || frame_sum[d] > pool_m[d]) begin
                pool_m[d] = frame_sum[d];
            end
        end
        pooled++;
        if (pooled > pool_nb_m) begin
            for (int d = 0; d < DEPTH_NB; d++) begin
                want[d] = IMG_WIDTH'(scale_value(pool_m[d] + bias_m[d]));
            end
            exp_q.push_back(want);
            pooled = 0;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_MAX) begin
                stop_error("timeout, expected results did not arrive");
            end
        end
        @(posedge clk);
    endtask

    task automatic wait_result_val();
        int waited;
        waited = 0;
        while (!result_val) begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_MAX) begin
                stop_error("timeout, result_val never rose");
            end
        end
    endtask

    always @(posedge clk) begin
        if (armed && (rst || rst_q)) begin
            assert (!image_rdy) else value_error("image_rdy", image_rdy, 0);
            assert (!kernel_rdy) else value_error("kernel_rdy", kernel_rdy, 0);
            assert (!result_val) else value_error("result_val", result_val, 0);
        end
        if (armed) begin
            assert (kernel_rdy == accept_q) else value_error("kernel_rdy", kernel_rdy, accept_q);
        end
        // stalled port must hold still
        if (armed && !rst && val_q && !rdy_q) begin
            assert (result_val) else value_error("result_val", result_val, 1);
            assert (result_bus == bus_q) else value_error("result_bus", result_bus, bus_q);
        end
        if (armed && !rst && result_val && result_rdy) begin
            if (exp_q.size() == 0) begin
                stop_error("result transfer with no expected value");
            end else begin
                want = exp_q.pop_front();
                for (int d = 0; d < DEPTH_NB; d++) begin
                    assert (result_bus[d] == want[d])
                    else value_error($sformatf("result_bus[%0d]", d),
                                     $signed(result_bus[d]), $signed(want[d]));
                end
            end
        end
        armed    <= armed | rst;
        rst_q    <= rst;
        accept_q <= image_val & image_rdy;
        val_q    <= result_val;
        rdy_q    <= result_rdy;
        bus_q    <= result_bus;
    end

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        cfg_data   = '0;
        cfg_addr   = '0;
        cfg_valid  = 1'b0;
        image_bus  = '0;
        image_last = 1'b0;
        image_val  = 1'b0;
        kernel_bus = '0;
        bias_bus   = '0;
        result_rdy = 1'b1;
        lfsr_q     = 32'hedfe;
        bypass_m   = 0;
        pool_nb_m  = 0;
        shift_m    = 0;
        pooled     = 0;
        armed      = 1'b0;
        rst_q      = 1'b0;
        accept_q   = 1'b0;
        val_q      = 1'b0;
        rdy_q      = 1'b0;
        bus_q      = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        // one frame per result, positive products
        write_cfg(CFG_LAYERS, 0, 0, 0);
        set_bias(0, 4);
        send_frame(4, MODE_POS);
        wait_drain();

        // negative sums through relu, then bypassed
        set_bias(0, 2);
        send_frame(3, MODE_NEG);
        wait_drain();
        write_cfg(CFG_LAYERS, 1, 0, 1);
        send_frame(2, MODE_NEG);
        wait_drain();
        write_cfg(3, 0, 0, 0);
        send_frame(2, MODE_NEG);
        wait_drain();

        // max pool over three frames, then saturation
        write_cfg(CFG_LAYERS, 0, 2, 2);
        set_bias(0, 4);
        send_frame(2, MODE_POS);
        send_frame(5, MODE_POS);
        send_frame(3, MODE_POS);
        wait_drain();
        write_cfg(CFG_LAYERS, 0, 0, 3);
        set_bias(127, 0);
        send_frame(10, MODE_BIG);
        wait_drain();

        // back-pressure with a second frame in flight
        write_cfg(CFG_LAYERS, 0, 0, 1);
        set_bias(-8, 4);
        result_rdy <= 1'b0;
        send_frame(3, MODE_MIX);
        wait_result_val();
        send_frame(4, MODE_MIX);
        repeat (6) @(posedge clk);
        result_rdy <= 1'b1;
        wait_drain();

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: layers.f
layers_pkg.sv
layers_cfg_decode.sv
layers_mac_front.sv
layers_pool_chain.sv
layers_result.sv
layers.sv
tb_layers.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_layers
FILELIST  = layers.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)
